// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= issue_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := tests failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100000 > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+hw
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/issue_regfile.sv
hw/issue_hazard_mask.sv
hw/issue_fork.sv
hw/issue_skid_buffer.sv
hw/issue_stage.sv
verif/issue_stage_assertions.sv
verif/issue_stage_tb.sv

// File: hw/isa_pkg.sv
`include "issue_consts.svh"

package isa_pkg;

  // Register index
  typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;

  // Data word
  typedef logic [`ISSUE_XLEN-1:0] word_t;

  // One bit per architectural register
  typedef logic [`ISSUE_NUM_REGS-1:0] reg_mask_t;

  // Execution port selector, also the port index in the issue stage
  typedef enum logic [`ISSUE_UNIT_W-1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_MEM    = 2'd1,
    UNIT_BRANCH = 2'd2
  } exec_unit_e;

endpackage

// File: hw/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// Architectural register count, x0 included
`define ISSUE_NUM_REGS 32

// Width of a data word
`define ISSUE_XLEN 32

// Execution ports behind the issue stage: ALU, memory, branch
`define ISSUE_NUM_PORTS 3

// Derived widths
`define ISSUE_REG_ADDR_W $clog2(`ISSUE_NUM_REGS)

`define ISSUE_UNIT_W 2

`endif

// File: hw/issue_fork.sv
`include "issue_consts.svh"

module issue_fork
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic                        clk_core,
  input  logic                        rst_core_n,
  input  logic                        stall_i,
  input  logic                        flush_i,
  input  issue_data_t                 data_i,
  input  logic                        valid_i,
  input  reg_mask_t                   src_mask_i,
  input  reg_mask_t                   rd_mask_i,
  input  reg_mask_t                   commit_mask_i,
  output reg_addr_t                   rs1_addr_o,
  output reg_addr_t                   rs2_addr_o,
  input  word_t                       rs1_data_i,
  input  word_t                       rs2_data_i,
  output logic                        hazard_o,
  output exec_op_t                    op_o,
  output logic [`ISSUE_NUM_PORTS-1:0] port_valid_o
);

  reg_mask_t                   pending_q;
  logic                        dispatch;
  logic [`ISSUE_NUM_PORTS-1:0] port_sel;

  // Operands are read straight from the register file
  assign rs1_addr_o = data_i.rs1;
  assign rs2_addr_o = data_i.rs2;

  // RAW and WAW against anything still in flight
  assign hazard_o = |((src_mask_i | rd_mask_i) & pending_q);

  // The top level only lets an edge through when the instruction is clear
  assign dispatch = valid_i && !stall_i;

  always_comb begin
    for (int k = 0; k < `ISSUE_NUM_PORTS; k++) begin
      port_sel[k] = valid_i && (data_i.unit == exec_unit_e'(k));
    end
  end

  // Scoreboard of destinations not yet committed
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      pending_q <= '0;
    end else if (flush_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~commit_mask_i) | (dispatch ? rd_mask_i : '0);
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      port_valid_o <= '0;
    end else if (flush_i) begin
      port_valid_o <= '0;
    end else if (!stall_i) begin
      port_valid_o <= port_sel;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall_i) begin
      op_o.funct     <= data_i.funct;
      op_o.rd        <= data_i.rd;
      op_o.writes_rd <= data_i.writes_rd;
      op_o.rs1_val   <= data_i.uses_rs1 ? rs1_data_i : '0;
      op_o.rs2_val   <= data_i.uses_rs2 ? rs2_data_i : '0;
      op_o.imm       <= data_i.imm;
    end
  end

endmodule

// File: hw/issue_hazard_mask.sv
module issue_hazard_mask
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic        clk_core,
  input  logic        rst_core_n,
  input  logic        stall_i,
  input  logic        flush_i,
  input  issue_data_t issue_data_i,
  input  logic        valid_i,
  output issue_data_t data_o,
  output logic        valid_o,
  output reg_mask_t   src_mask_o,
  output reg_mask_t   rd_mask_o
);

  reg_mask_t src_mask_d;
  reg_mask_t rd_mask_d;

  // One-hot masks of the registers this instruction touches
  always_comb begin
    src_mask_d = '0;
    rd_mask_d  = '0;
    if (issue_data_i.uses_rs1) begin
      src_mask_d[issue_data_i.rs1] = 1'b1;
    end
    if (issue_data_i.uses_rs2) begin
      src_mask_d[issue_data_i.rs2] = 1'b1;
    end
    // x0 is never tracked as a destination
    if (issue_data_i.writes_rd && issue_data_i.rd != '0) begin
      rd_mask_d[issue_data_i.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_core) begin
    if (!stall_i) begin
      data_o     <= issue_data_i;
      src_mask_o <= src_mask_d;
      rd_mask_o  <= rd_mask_d;
    end
  end

endmodule

// File: hw/issue_pkg.sv
package issue_pkg;

  import isa_pkg::*;

  // Decoded instruction entering the issue stage
  typedef struct packed {
    exec_unit_e unit;
    logic [3:0] funct;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    word_t      imm;
  } issue_data_t;

  // Operation handed to one execution port, operands already read
  typedef struct packed {
    logic [3:0] funct;
    reg_addr_t  rd;
    logic       writes_rd;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm;
  } exec_op_t;

endpackage

// File: hw/issue_regfile.sv
`include "issue_consts.svh"

module issue_regfile
  import isa_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  // x0 has no storage
  word_t regs_q [1:`ISSUE_NUM_REGS-1];

  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    // Same-edge write is visible to the reader
    if (wr_en_i && wr_addr_i == addr) begin
      return wr_data_i;
    end
    return regs_q[addr];
  endfunction

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 1; i < `ISSUE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

// File: hw/issue_skid_buffer.sv
module issue_skid_buffer
  import issue_pkg::*;
(
  input  logic     clk_core,
  input  logic     rst_core_n,
  input  logic     flush_i,
  input  exec_op_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output exec_op_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  exec_op_t skid_q;
  logic     skid_valid_q;
  logic     in_fire;
  logic     out_free;
  logic     valid_d;
  logic     skid_valid_d;

  assign in_fire  = valid_i && ready_o;
  // Output entry is empty or being drained this cycle
  assign out_free = !valid_o || ready_i;

  always_comb begin
    valid_d      = valid_o;
    skid_valid_d = skid_valid_q;
    if (out_free) begin
      // Skid entry drains first, input is blocked while it is full
      valid_d      = skid_valid_q || in_fire;
      skid_valid_d = 1'b0;
    end else if (in_fire) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o      <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_o      <= 1'b0;
    end else if (flush_i) begin
      valid_o      <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_o      <= 1'b1;
    end else begin
      valid_o      <= valid_d;
      skid_valid_q <= skid_valid_d;
      ready_o      <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk_core) begin
    if (out_free) begin
      data_o <= skid_valid_q ? skid_q : data_i;
    end else if (in_fire) begin
      skid_q <= data_i;
    end
  end

endmodule

// File: hw/issue_stage.sv
`include "issue_consts.svh"

module issue_stage
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic                        clk_core,
  input  logic                        rst_core_n,
  input  logic                        flush_req_i,
  output logic                        flush_ack_o,
  input  issue_data_t                 issue_data_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  input  logic                        wr_en_i,
  input  reg_addr_t                   wr_addr_i,
  input  word_t                       wr_data_i,
  input  reg_mask_t                   commit_mask_i,
  output exec_op_t                    port_op_o [`ISSUE_NUM_PORTS],
  output logic [`ISSUE_NUM_PORTS-1:0] port_valid_o,
  input  logic [`ISSUE_NUM_PORTS-1:0] port_ready_i
);

  reg_addr_t                   rs1_addr;
  reg_addr_t                   rs2_addr;
  word_t                       rs1_data;
  word_t                       rs2_data;
  issue_data_t                 hm_data;
  logic                        hm_valid;
  reg_mask_t                   src_mask;
  reg_mask_t                   rd_mask;
  logic                        hazard;
  exec_op_t                    fork_op;
  logic [`ISSUE_NUM_PORTS-1:0] fork_valid;
  logic [`ISSUE_NUM_PORTS-1:0] buf_valid;
  logic [`ISSUE_NUM_PORTS-1:0] buf_ready;
  logic                        buf_stall;
  logic                        stall;
  logic                        fork_taken_q;

  assign buf_stall = ~&buf_ready;
  assign stall     = (hazard && hm_valid) || buf_stall;
  assign ready_o   = !stall;

  // Fork output already handed over while the pipe is held
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      fork_taken_q <= 1'b0;
    end else if (flush_req_i) begin
      fork_taken_q <= 1'b0;
    end else begin
      fork_taken_q <= stall && (fork_taken_q || !buf_stall);
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

  issue_regfile regfile_inst (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_en_i    (wr_en_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  issue_hazard_mask hazard_mask_inst (
    .clk_core     (clk_core),
    .rst_core_n   (rst_core_n),
    .stall_i      (stall),
    .flush_i      (flush_req_i),
    .issue_data_i (issue_data_i),
    .valid_i      (valid_i),
    .data_o       (hm_data),
    .valid_o      (hm_valid),
    .src_mask_o   (src_mask),
    .rd_mask_o    (rd_mask)
  );

  issue_fork fork_inst (
    .clk_core      (clk_core),
    .rst_core_n    (rst_core_n),
    .stall_i       (stall),
    .flush_i       (flush_req_i),
    .data_i        (hm_data),
    .valid_i       (hm_valid),
    .src_mask_i    (src_mask),
    .rd_mask_i     (rd_mask),
    .commit_mask_i (commit_mask_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .hazard_o      (hazard),
    .op_o          (fork_op),
    .port_valid_o  (fork_valid)
  );

  // One skid buffer per execution port, indexed by exec_unit_e
  for (genvar k = 0; k < `ISSUE_NUM_PORTS; k++) begin : g_port
    // Only push when every buffer can take it
    assign buf_valid[k] = fork_valid[k] && !buf_stall && !fork_taken_q;

    issue_skid_buffer skid_inst (
      .clk_core   (clk_core),
      .rst_core_n (rst_core_n),
      .flush_i    (flush_req_i),
      .data_i     (fork_op),
      .valid_i    (buf_valid[k]),
      .ready_o    (buf_ready[k]),
      .data_o     (port_op_o[k]),
      .valid_o    (port_valid_o[k]),
      .ready_i    (port_ready_i[k])
    );
  end

endmodule

// File: verif/issue_stage_assertions.sv
`include "issue_consts.svh"

module issue_stage_assertions
  import isa_pkg::*;
  import issue_pkg::*;
(
  input logic                        clk_core,
  input logic                        rst_core_n,
  input logic                        flush_req_i,
  input logic                        flush_ack_o,
  input logic                        ready_o,
  input issue_data_t                 issue_data_i,
  input logic                        valid_i,
  input logic                        hazard_i,
  input logic                        hm_valid_i,
  input logic                        wr_en_i,
  input reg_addr_t                   wr_addr_i,
  input word_t                       wr_data_i,
  input reg_mask_t                   commit_mask_i,
  input exec_op_t                    port_op_o [`ISSUE_NUM_PORTS],
  input logic [`ISSUE_NUM_PORTS-1:0] port_valid_o,
  input logic [`ISSUE_NUM_PORTS-1:0] port_ready_i
);

  int                          err_count = 0;
  word_t                       shadow_rf [`ISSUE_NUM_REGS];
  reg_mask_t                   pend_q;
  reg_mask_t                   fired_rd;
  logic [15:0]                 writer_seq_q [`ISSUE_NUM_REGS];
  logic [15:0]                 last_seq_q [`ISSUE_NUM_PORTS];
  logic [`ISSUE_NUM_PORTS-1:0] seen_q;
  logic [`ISSUE_NUM_PORTS-1:0] fire;
  logic                        unit_bad;
  logic                        value_bad;
  logic                        dest_bad;
  logic                        src_bad;
  logic                        order_bad;
  logic                        lat_free;
  logic [2:0]                  lat_v_q;
  exec_unit_e                  lat_unit_q [3];
  logic [15:0]                 lat_seq_q [3];

  function automatic word_t expect_val(logic used, reg_addr_t r);
    if (!used || r == '0) begin
      return '0;
    end
    return shadow_rf[r];
  endfunction

  // Shadow register file, written from the writeback port only
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
        shadow_rf[i] <= '0;
      end
    end else if (wr_en_i && wr_addr_i != '0) begin
      shadow_rf[wr_addr_i] <= wr_data_i;
    end
  end

  // Source fields travel in funct (use flags, unit) and imm (addresses, sequence)
  always_comb begin
    exec_op_t    op;
    reg_addr_t   r1;
    reg_addr_t   r2;
    logic [15:0] seq;
    unit_bad  = 1'b0;
    value_bad = 1'b0;
    dest_bad  = 1'b0;
    src_bad   = 1'b0;
    order_bad = 1'b0;
    fired_rd  = '0;
    for (int k = 0; k < `ISSUE_NUM_PORTS; k++) begin
      fire[k] = port_valid_o[k] && port_ready_i[k];
      op  = port_op_o[k];
      r1  = op.imm[31:27];
      r2  = op.imm[26:22];
      seq = op.imm[15:0];
      if (fire[k]) begin
        unit_bad  |= op.funct[3:2] != k[1:0];
        value_bad |= op.rs1_val != expect_val(op.funct[0], r1);
        value_bad |= op.rs2_val != expect_val(op.funct[1], r2);
        dest_bad  |= op.writes_rd && op.rd != '0 && pend_q[op.rd];
        // Only an older writer still pending blocks a reader
        src_bad   |= op.funct[0] && r1 != '0 && pend_q[r1] && writer_seq_q[r1] < seq;
        src_bad   |= op.funct[1] && r2 != '0 && pend_q[r2] && writer_seq_q[r2] < seq;
        order_bad |= seen_q[k] && seq <= last_seq_q[k];
        if (op.writes_rd && op.rd != '0) begin
          fired_rd[op.rd] = 1'b1;
        end
      end
    end
  end

  // Shadow scoreboard, set by operations leaving the ports
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      pend_q <= '0;
      seen_q <= '0;
      for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
        writer_seq_q[i] <= '0;
      end
      for (int k = 0; k < `ISSUE_NUM_PORTS; k++) begin
        last_seq_q[k] <= '0;
      end
    end else begin
      pend_q <= flush_req_i ? '0 : ((pend_q & ~commit_mask_i) | fired_rd);
      for (int k = 0; k < `ISSUE_NUM_PORTS; k++) begin
        if (fire[k]) begin
          seen_q[k]     <= 1'b1;
          last_seq_q[k] <= port_op_o[k].imm[15:0];
          if (port_op_o[k].writes_rd && port_op_o[k].rd != '0) begin
            writer_seq_q[port_op_o[k].rd] <= port_op_o[k].imm[15:0];
          end
        end
      end
    end
  end

  // Every port free and no flush at this edge
  assign lat_free = port_ready_i == '1 && !flush_req_i;

  // Accepted instructions that never stall, due on their port after two edges
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      lat_v_q <= '0;
    end else begin
      lat_v_q[0] <= valid_i && ready_o && lat_free;
      lat_v_q[1] <= lat_v_q[0] && ready_o && lat_free;
      lat_v_q[2] <= lat_v_q[1] && lat_free;
    end
  end

  always_ff @(posedge clk_core) begin
    lat_unit_q[0] <= issue_data_i.unit;
    lat_unit_q[1] <= lat_unit_q[0];
    lat_unit_q[2] <= lat_unit_q[1];
    lat_seq_q[0]  <= issue_data_i.imm[15:0];
    lat_seq_q[1]  <= lat_seq_q[0];
    lat_seq_q[2]  <= lat_seq_q[1];
  end

  assert property (@(posedge clk_core)
    !rst_core_n |-> !ready_o && port_valid_o == '0 && !flush_ack_o)
    else begin
      err_count++;
      $error("ERR %0t: outputs active during reset", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    flush_ack_o == $past(flush_req_i))
    else begin
      err_count++;
      $error("ERR %0t: flush_ack_o is not flush_req_i delayed by one cycle", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    flush_req_i |=> port_valid_o == '0)
    else begin
      err_count++;
      $error("ERR %0t: port valid after flush", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n) !unit_bad)
    else begin
      err_count++;
      $error("ERR %0t: operation left on the wrong port", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n) !value_bad)
    else begin
      err_count++;
      $error("ERR %0t: operand value differs from shadow register file", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n) !dest_bad)
    else begin
      err_count++;
      $error("ERR %0t: destination register still pending", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n) !src_bad)
    else begin
      err_count++;
      $error("ERR %0t: source register still pending", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n) !order_bad)
    else begin
      err_count++;
      $error("ERR %0t: port delivered out of order or twice", $time);
    end

  // A buffer can only be full after its port was held the cycle before
  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    $past(rst_core_n) && !ready_o
      |-> (hazard_i && hm_valid_i) || $past(|(port_valid_o & ~port_ready_i)))
    else begin
      err_count++;
      $error("ERR %0t: ready_o low without hazard or full buffer", $time);
    end

  assert property (@(posedge clk_core) disable iff (!rst_core_n)
    lat_v_q[2] |-> port_valid_o[lat_unit_q[2]]
      && port_op_o[lat_unit_q[2]].imm[15:0] == lat_seq_q[2])
    else begin
      err_count++;
      $error("ERR %0t: instruction not on its port two edges after acceptance", $time);
    end

  for (genvar k = 0; k < `ISSUE_NUM_PORTS; k++) begin : g_hold
    assert property (@(posedge clk_core) disable iff (!rst_core_n)
      (port_valid_o[k] && !port_ready_i[k] && !flush_req_i)
        |=> port_valid_o[k] && $stable(port_op_o[k]))
      else begin
        err_count++;
        $error("ERR %0t: stalled port output changed", $time);
      end
  end

endmodule

// File: verif/issue_stage_tb.sv
`include "issue_consts.svh"

module issue_stage_tb
  import isa_pkg::*;
  import issue_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_PHASES   = 3;
  localparam int PHASE_CYCLES = 400;
  localparam int DRAIN_EVERY  = 100;
  localparam int DRAIN_MAX    = 40;
  localparam int NUM_WRITES   = 4;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_PHASES * (PHASE_CYCLES
    + (PHASE_CYCLES / DRAIN_EVERY) * (DRAIN_MAX + NUM_WRITES + 2)) + 50;
  localparam reg_addr_t HOT_REG = 5'd5;

  logic                        clk_core;
  logic                        rst_core_n;
  logic                        flush_req_i;
  logic                        flush_ack_o;
  issue_data_t                 issue_data_i;
  logic                        valid_i;
  logic                        ready_o;
  logic                        wr_en_i;
  reg_addr_t                   wr_addr_i;
  word_t                       wr_data_i;
  reg_mask_t                   commit_mask_i;
  exec_op_t                    port_op_o [`ISSUE_NUM_PORTS];
  logic [`ISSUE_NUM_PORTS-1:0] port_valid_o;
  logic [`ISSUE_NUM_PORTS-1:0] port_ready_i;

  logic [31:0] lfsr_q = 32'h90cc;
  reg_mask_t   left_mask = '0;
  logic [15:0] seq_cnt = '0;
  logic        holding = 1'b0;
  logic        issue_en = 1'b0;
  logic        rand_ready = 1'b0;
  logic        flush_en = 1'b0;
  int          tb_errors = 0;
  int          total_errors;

  issue_stage issue_stage_inst (.*);

  initial begin
    clk_core = 1'b0;
    forever #(CLK_PERIOD / 2) clk_core = ~clk_core;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  // Bias toward one register so hazards show up often
  function automatic reg_addr_t pick_reg();
    if (rand_bits(2) == 0) begin
      return HOT_REG;
    end
    return reg_addr_t'(rand_bits(5));
  endfunction

  task automatic new_instr();
    issue_data_t d;
    logic [1:0]  u;
    u           = 2'(rand_bits(2));
    d.unit      = (u == 2'd3) ? UNIT_ALU : exec_unit_e'(u);
    d.rd        = pick_reg();
    d.rs1       = pick_reg();
    d.rs2       = pick_reg();
    d.uses_rs1  = 1'(rand_bits(1));
    d.uses_rs2  = 1'(rand_bits(1));
    d.writes_rd = 1'(rand_bits(1));
    d.funct     = {d.unit, d.uses_rs2, d.uses_rs1};
    d.imm       = {d.rs1, d.rs2, 6'd0, seq_cnt};
    issue_data_i = d;
    valid_i      = rand_bits(2) != 0;
  endtask

  function automatic logic pipe_idle();
    return port_valid_o == '0 && !issue_stage_inst.hm_valid
      && issue_stage_inst.fork_valid == '0 && !holding;
  endfunction

  task automatic step();
    reg_mask_t commit;
    @(negedge clk_core);
    if (!holding) begin
      if (issue_en) begin
        new_instr();
      end else begin
        valid_i = 1'b0;
      end
    end
    port_ready_i = rand_ready ? `ISSUE_NUM_PORTS'(rand_bits(`ISSUE_NUM_PORTS)) : '1;
    flush_req_i  = flush_en && rand_bits(5) == 0;
    // Only registers whose writer already left may commit
    commit = issue_en ? (left_mask & rand_bits(32)) : left_mask;
    if (issue_en && rand_bits(3) != 0) begin
      commit[HOT_REG] = 1'b0;
    end
    commit_mask_i = commit;
    left_mask     = left_mask & ~commit;
    #10;
    holding = valid_i && !ready_o && !flush_req_i;
    if (valid_i && ready_o) begin
      seq_cnt++;
    end
    for (int k = 0; k < `ISSUE_NUM_PORTS; k++) begin
      if (port_valid_o[k] && port_ready_i[k] && port_op_o[k].writes_rd) begin
        left_mask[port_op_o[k].rd] = port_op_o[k].rd != '0;
      end
    end
    if (flush_req_i) begin
      left_mask = '0;
    end
  endtask

  // Register writes happen only with nothing in flight
  task automatic drain_and_write();
    int n;
    issue_en   = 1'b0;
    rand_ready = 1'b0;
    flush_en   = 1'b0;
    n = 0;
    do begin
      step();
      n++;
    end while (!pipe_idle() && n < DRAIN_MAX);
    if (!pipe_idle()) begin
      $display("pipeline did not drain within %0d cycles at %0t", DRAIN_MAX, $time);
      tb_errors++;
    end
    for (int i = 0; i < NUM_WRITES; i++) begin
      @(negedge clk_core);
      commit_mask_i = '0;
      wr_en_i       = 1'b1;
      wr_addr_i     = reg_addr_t'(rand_bits(5));
      wr_data_i     = rand_bits(32);
    end
    @(negedge clk_core);
    wr_en_i = 1'b0;
  endtask

  task automatic run_phase(logic ready_rand, logic with_flush);
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      if (i % DRAIN_EVERY == 0) begin
        drain_and_write();
      end
      issue_en   = 1'b1;
      rand_ready = ready_rand;
      flush_en   = with_flush;
      step();
    end
  endtask

  initial begin
    rst_core_n    = 1'b0;
    flush_req_i   = 1'b0;
    issue_data_i  = '0;
    valid_i       = 1'b0;
    wr_en_i       = 1'b0;
    wr_addr_i     = '0;
    wr_data_i     = '0;
    commit_mask_i = '0;
    port_ready_i  = '0;
    repeat (RESET_CYCLES) @(negedge clk_core);
    rst_core_n = 1'b1;
    // Free-flowing ports, then back-pressure, then back-pressure with flushes
    run_phase(1'b0, 1'b0);
    run_phase(1'b1, 1'b0);
    run_phase(1'b1, 1'b1);
    drain_and_write();
    total_errors = issue_stage_inst.checker_inst.err_count + tb_errors;
    $display("checks done: %0d assertion failures, %0d stimulus errors",
             issue_stage_inst.checker_inst.err_count, tb_errors);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

endmodule

bind issue_stage issue_stage_assertions checker_inst (
  .clk_core      (clk_core),
  .rst_core_n    (rst_core_n),
  .flush_req_i   (flush_req_i),
  .flush_ack_o   (flush_ack_o),
  .ready_o       (ready_o),
  .issue_data_i  (issue_data_i),
  .valid_i       (valid_i),
  .hazard_i      (hazard),
  .hm_valid_i    (hm_valid),
  .wr_en_i       (wr_en_i),
  .wr_addr_i     (wr_addr_i),
  .wr_data_i     (wr_data_i),
  .commit_mask_i (commit_mask_i),
  .port_op_o     (port_op_o),
  .port_valid_o  (port_valid_o),
  .port_ready_i  (port_ready_i)
);
